/* logic/vec_pkg.sv */
// NrLanes must be a power of two; elem_idx_t and pe_idx_t must cover ElemsPerLane and NrPEs
`default_nettype none

package vec_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int unsigned NrLanes      = 4;
  // Lanes plus the load/store unit
  localparam int unsigned NrPEs        = NrLanes + 1;
  localparam int unsigned ElemsPerLane = 4;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemWidth    = 32;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  // Element l of a beat belongs to lane l
  typedef elem_t [NrLanes-1:0]  beat_t;

  typedef logic [2:0] vreg_idx_t;
  typedef logic [1:0] elem_idx_t;
  typedef logic [2:0] pe_idx_t;

  // Position of the load/store unit in the ready and done vectors
  localparam pe_idx_t LsuPeIdx = pe_idx_t'(NrLanes);

  // Encodings 4 to 7 are illegal
  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,
    OP_VLOAD   = 3'd1,
    OP_VLOADBC = 3'd2,
    OP_VSTORE  = 3'd3
  } vec_op_e;

endpackage : vec_pkg

`default_nettype wire

/* logic/pe_req_if.sv */
// Each processing element drives only its own ready and done bit; one instruction in flight
`timescale 1ns/1ps
`default_nettype none

interface pe_req_if (
  input wire logic clk_i
);
  import vec_pkg::*;

  logic                 valid;
  vec_op_e              op;
  vreg_idx_t            vd;
  vreg_idx_t            vs1;
  vreg_idx_t            vs2;
  logic     [NrPEs-1:0] ready;
  logic     [NrPEs-1:0] done;

  modport seq (
    output valid, op, vd, vs1, vs2,
    input  ready, done
  );

  modport pe (
    input  valid, op, vd, vs1, vs2,
    output ready, done
  );

  // A presented instruction holds until every element has taken it
  assert property (@(posedge clk_i) valid && !(&ready) |=>
                   valid && $stable(op) && $stable(vd) && $stable(vs1) && $stable(vs2))
    else $error("pe_req_if: instruction dropped or changed before transfer");

endinterface : pe_req_if

`default_nettype wire

/* logic/stream_fifo.sv */
// Two entries; in_ready_o depends on the fill count only, so it never waits on in_valid_i
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire payload_t in_data_i,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  output payload_t      out_data_o,
  output logic          out_valid_o,
  input  wire logic     out_ready_i
);

  payload_t   mem_q [2];
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  assign in_ready_o  = (cnt_q != 2'd2);
  assign out_valid_o = (cnt_q != 2'd0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  // Write slot sits right after the last stored entry
  always_ff @(posedge clk_i) begin
    if (push) mem_q[rd_ptr_q ^ cnt_q[0]] <= in_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (pop) rd_ptr_q <= !rd_ptr_q;
      cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("stream_fifo: output changed while stalled");

endmodule : stream_fifo

`default_nettype wire

/* logic/vec_dispatcher.sv */
// Accepts one request at a time; req_ready_o stays low until the response has transferred
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  // Request
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  input  wire vec_pkg::vec_op_e    req_op_i,
  input  wire vec_pkg::vreg_idx_t  req_vd_i,
  input  wire vec_pkg::vreg_idx_t  req_vs1_i,
  input  wire vec_pkg::vreg_idx_t  req_vs2_i,
  // Response
  output logic                     resp_valid_o,
  output logic                     resp_error_o,
  input  wire logic                resp_ready_i,
  // To the sequencer
  output logic                     ins_valid_o,
  output vec_pkg::vec_op_e         ins_op_o,
  output vec_pkg::vreg_idx_t       ins_vd_o,
  output vec_pkg::vreg_idx_t       ins_vs1_o,
  output vec_pkg::vreg_idx_t       ins_vs2_o,
  input  wire logic                ins_done_i
);
  import vec_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_RESP} state_e;

  state_e state_q;
  logic   accept;
  logic   legal;

  assign req_ready_o  = (state_q == ST_IDLE);
  assign resp_valid_o = (state_q == ST_RESP);
  assign accept       = req_valid_i && req_ready_o;
  assign legal        = req_op_i inside {OP_VADD, OP_VLOAD, OP_VLOADBC, OP_VSTORE};

  // Latched instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ins_op_o  <= req_op_i;
      ins_vd_o  <= req_vd_i;
      ins_vs1_o <= req_vs1_i;
      ins_vs2_o <= req_vs2_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      ins_valid_o  <= 1'b0;
      resp_error_o <= 1'b0;
    end else begin
      // One-cycle hand-off to the sequencer
      ins_valid_o <= accept && legal;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q      <= legal ? ST_BUSY : ST_RESP;
            resp_error_o <= !legal;
          end
        end
        ST_BUSY: if (ins_done_i) state_q <= ST_RESP;
        ST_RESP: if (resp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule : vec_dispatcher

`default_nettype wire

/* logic/vec_sequencer.sv */
// Expects a new instruction only after ins_done_o of the previous one
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  // From the dispatcher
  input  wire logic                ins_valid_i,
  input  wire vec_pkg::vec_op_e    ins_op_i,
  input  wire vec_pkg::vreg_idx_t  ins_vd_i,
  input  wire vec_pkg::vreg_idx_t  ins_vs1_i,
  input  wire vec_pkg::vreg_idx_t  ins_vs2_i,
  output logic                     ins_done_o,
  // To the processing elements
  pe_req_if.seq                    pe
);
  import vec_pkg::*;

  logic             active_q;
  logic [NrPEs-1:0] done_q;
  logic [NrPEs-1:0] done_all;

  // Sticky done bits plus this cycle's pulses
  assign done_all = done_q | pe.done;

  always_ff @(posedge clk_i) begin
    if (ins_valid_i) begin
      pe.op  <= ins_op_i;
      pe.vd  <= ins_vd_i;
      pe.vs1 <= ins_vs1_i;
      pe.vs2 <= ins_vs2_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pe.valid   <= 1'b0;
      active_q   <= 1'b0;
      done_q     <= '0;
      ins_done_o <= 1'b0;
    end else begin
      ins_done_o <= 1'b0;
      if (ins_valid_i) begin
        pe.valid <= 1'b1;
        active_q <= 1'b1;
      end else if (pe.valid && (&pe.ready)) begin
        pe.valid <= 1'b0;
      end
      if (active_q) begin
        if (&done_all) begin
          done_q     <= '0;
          active_q   <= 1'b0;
          ins_done_o <= 1'b1;
        end else begin
          done_q <= done_all;
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) (|pe.done) |-> active_q)
    else $error("vec_sequencer: done pulse with no instruction outstanding");

endmodule : vec_sequencer

`default_nettype wire

/* logic/vec_lane.sv */
// Store reads vs1; a broadcast value is written to vd only while a broadcast load runs here
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter vec_pkg::pe_idx_t LaneId = '0
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  pe_req_if.pe                  pe,
  // Load writes
  input  wire logic             ld_we_i,
  input  wire vec_pkg::elem_t   ld_elem_i,
  // Broadcast chain
  input  wire vec_pkg::elem_t   bc_data_i,
  input  wire logic             bc_valid_i,
  output logic                  bc_ready_o,
  output vec_pkg::elem_t        bc_data_o,
  output logic                  bc_valid_o,
  input  wire logic             bc_ready_i,
  // Store operands
  output vec_pkg::elem_t        st_elem_o,
  output logic                  st_valid_o,
  input  wire logic             st_ready_i
);
  import vec_pkg::*;

  elem_t     vrf_q [NrVRegs][ElemsPerLane];
  logic      busy_q;
  logic      done_q;
  elem_idx_t cnt_q;
  vec_op_e   op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;

  logic accept;
  logic add_en;
  logic st_fire;
  logic bc_fire;
  logic bc_wr;
  logic step;

  assign pe.ready[LaneId] = !busy_q;
  assign pe.done[LaneId]  = done_q;
  assign accept           = pe.valid && (&pe.ready);

  assign add_en     = busy_q && (op_q == OP_VADD);
  assign st_valid_o = busy_q && (op_q == OP_VSTORE);
  assign st_elem_o  = vrf_q[vs1_q][cnt_q];
  assign st_fire    = st_valid_o && st_ready_i;
  // Each of these advances the element counter by one
  assign step       = add_en || ld_we_i || st_fire;

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (add_en) begin
      vrf_q[vd_q][cnt_q] <= vrf_q[vs1_q][cnt_q] + vrf_q[vs2_q][cnt_q];
    end else if (ld_we_i) begin
      vrf_q[vd_q][cnt_q] <= ld_elem_i;
    end else if (bc_wr) begin
      for (int e = 0; e < ElemsPerLane; e++) begin
        vrf_q[vd_q][e] <= bc_data_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= pe.op;
      vd_q  <= pe.vd;
      vs1_q <= pe.vs1;
      vs2_q <= pe.vs2;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (step) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == elem_idx_t'(ElemsPerLane - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (bc_wr) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Broadcast chain stage
  //////////////////////////////////////////////////

  // Takes a new value when empty or when the next lane drains it
  assign bc_ready_o = !bc_valid_o || bc_ready_i;
  assign bc_fire    = bc_valid_i && bc_ready_o;
  assign bc_wr      = bc_fire && busy_q && (op_q == OP_VLOADBC);

  always_ff @(posedge clk_i) begin
    if (bc_fire) bc_data_o <= bc_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bc_valid_o <= 1'b0;
    end else if (bc_fire) begin
      bc_valid_o <= 1'b1;
    end else if (bc_ready_i) begin
      bc_valid_o <= 1'b0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   ld_we_i |-> busy_q && (op_q == OP_VLOAD))
    else $error("vec_lane: load strobe outside a load");

endmodule : vec_lane

`default_nettype wire

/* logic/vec_lsu.sv */
// Vectors move as ElemsPerLane beats; a broadcast load takes element 0 of a single beat
`timescale 1ns/1ps
`default_nettype none

module vec_lsu (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  pe_req_if.pe                               pe,
  // Load stream
  input  wire logic                          ld_valid_i,
  output logic                               ld_ready_o,
  input  wire vec_pkg::beat_t                ld_data_i,
  // Load writes to the lanes
  output logic        [vec_pkg::NrLanes-1:0] ld_we_o,
  output vec_pkg::beat_t                     ld_elem_o,
  // Broadcast buffer output
  output vec_pkg::elem_t                     bc_data_o,
  output logic                               bc_valid_o,
  input  wire logic                          bc_ready_i,
  // Store operands from the lanes
  input  wire vec_pkg::beat_t                st_elem_i,
  input  wire logic   [vec_pkg::NrLanes-1:0] st_valid_i,
  output logic        [vec_pkg::NrLanes-1:0] st_ready_o,
  // Store stream
  output logic                               st_valid_o,
  input  wire logic                          st_ready_i,
  output vec_pkg::beat_t                     st_data_o
);
  import vec_pkg::*;

  logic      busy_q;
  logic      done_q;
  vec_op_e   op_q;
  elem_idx_t beat_cnt_q;

  logic accept, is_ld, is_bc, is_st;
  logic ld_fire, bc_in_ready, bc_push;
  logic st_push_valid, st_push_ready, st_out_fire;
  logic beat_ev, last_beat;

  assign pe.ready[LsuPeIdx] = !busy_q;
  assign pe.done[LsuPeIdx]  = done_q;
  assign accept             = pe.valid && (&pe.ready);

  assign is_ld = busy_q && (op_q == OP_VLOAD);
  assign is_bc = busy_q && (op_q == OP_VLOADBC);
  assign is_st = busy_q && (op_q == OP_VSTORE);

  // Load beats go to the lanes or, for a broadcast, to the buffer
  assign ld_ready_o = is_ld || (is_bc && bc_in_ready);
  assign ld_fire    = ld_valid_i && ld_ready_o;
  assign ld_we_o    = {NrLanes{ld_fire && is_ld}};
  assign ld_elem_o  = ld_data_i;
  assign bc_push    = ld_fire && is_bc;

  stream_fifo #(.payload_t(elem_t)) i_bc_fifo (
    .clk_i      (clk_i               ),
    .rst_n_i    (rst_n_i             ),
    .in_data_i  (ld_data_i[0]        ),
    .in_valid_i (is_bc && ld_valid_i ),
    .in_ready_o (bc_in_ready         ),
    .out_data_o (bc_data_o           ),
    .out_valid_o(bc_valid_o          ),
    .out_ready_i(bc_ready_i          )
  );

  // All lanes pop together once every operand is there
  assign st_push_valid = is_st && (&st_valid_i);
  assign st_ready_o    = {NrLanes{st_push_valid && st_push_ready}};

  stream_fifo #(.payload_t(beat_t)) i_st_fifo (
    .clk_i      (clk_i        ),
    .rst_n_i    (rst_n_i      ),
    .in_data_i  (st_elem_i    ),
    .in_valid_i (st_push_valid),
    .in_ready_o (st_push_ready),
    .out_data_o (st_data_o    ),
    .out_valid_o(st_valid_o   ),
    .out_ready_i(st_ready_i   )
  );

  assign st_out_fire = st_valid_o && st_ready_i;
  assign beat_ev     = (ld_fire && is_ld) || (st_out_fire && is_st);
  assign last_beat   = (beat_cnt_q == elem_idx_t'(ElemsPerLane - 1));

  always_ff @(posedge clk_i) begin
    if (accept) op_q <= pe.op;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      // Nothing to move for an add, so report right away
      done_q <= (accept && (pe.op == OP_VADD)) || bc_push || (beat_ev && last_beat);
      if (accept && (pe.op != OP_VADD)) begin
        busy_q     <= 1'b1;
        beat_cnt_q <= '0;
      end else if (bc_push || (beat_ev && last_beat)) begin
        busy_q <= 1'b0;
      end else if (beat_ev) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule : vec_lsu

`default_nettype wire

/* logic/vec_top.sv */
// One instruction in flight; load and store beats carry element l of every lane in slot l
`timescale 1ns/1ps
`default_nettype none

module vec_top (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  // Request and response
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  input  wire vec_pkg::vec_op_e    req_op_i,
  input  wire vec_pkg::vreg_idx_t  req_vd_i,
  input  wire vec_pkg::vreg_idx_t  req_vs1_i,
  input  wire vec_pkg::vreg_idx_t  req_vs2_i,
  output logic                     resp_valid_o,
  input  wire logic                resp_ready_i,
  output logic                     resp_error_o,
  // Memory beat streams
  input  wire logic                ld_valid_i,
  output logic                     ld_ready_o,
  input  wire vec_pkg::beat_t      ld_data_i,
  output logic                     st_valid_o,
  input  wire logic                st_ready_i,
  output vec_pkg::beat_t           st_data_o
);
  import vec_pkg::*;

  //////////////////////////////////////////////////
  // Dispatcher and sequencer
  //////////////////////////////////////////////////

  logic      ins_valid, ins_done;
  vec_op_e   ins_op;
  vreg_idx_t ins_vd, ins_vs1, ins_vs2;

  pe_req_if pe_req (.clk_i(clk_i));

  vec_dispatcher i_dispatcher (
    .clk_i, .rst_n_i,
    .req_valid_i, .req_ready_o, .req_op_i, .req_vd_i, .req_vs1_i, .req_vs2_i,
    .resp_valid_o, .resp_error_o, .resp_ready_i,
    .ins_valid_o(ins_valid), .ins_op_o(ins_op), .ins_vd_o(ins_vd),
    .ins_vs1_o  (ins_vs1  ), .ins_vs2_o(ins_vs2), .ins_done_i(ins_done)
  );

  vec_sequencer i_sequencer (
    .clk_i, .rst_n_i,
    .ins_valid_i(ins_valid), .ins_op_i(ins_op), .ins_vd_i(ins_vd),
    .ins_vs1_i  (ins_vs1  ), .ins_vs2_i(ins_vs2), .ins_done_o(ins_done),
    .pe         (pe_req.seq)
  );

  //////////////////////////////////////////////////
  // Lanes and broadcast chain
  //////////////////////////////////////////////////

  logic  [NrLanes-1:0] ld_we;
  beat_t               ld_elem, st_elem;
  logic  [NrLanes-1:0] st_valid, st_ready;
  elem_t               bc_buf_data;
  logic                bc_buf_valid, bc_buf_ready;
  beat_t               bc_lane_data_in, bc_lane_data_out;
  logic  [NrLanes-1:0] bc_lane_valid_in, bc_lane_valid_out;
  logic  [NrLanes-1:0] bc_lane_ready_in, bc_lane_ready_out;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(.LaneId(pe_idx_t'(l))) i_lane (
      .clk_i, .rst_n_i,
      .pe        (pe_req.pe           ),
      .ld_we_i   (ld_we[l]            ),
      .ld_elem_i (ld_elem[l]          ),
      .bc_data_i (bc_lane_data_in[l]  ),
      .bc_valid_i(bc_lane_valid_in[l] ),
      .bc_ready_o(bc_lane_ready_out[l]),
      .bc_data_o (bc_lane_data_out[l] ),
      .bc_valid_o(bc_lane_valid_out[l]),
      .bc_ready_i(bc_lane_ready_in[l] ),
      .st_elem_o (st_elem[l]          ),
      .st_valid_o(st_valid[l]         ),
      .st_ready_i(st_ready[l]         )
    );

    // Lane 0 is fed by the broadcast buffer
    if (l == 0) begin : gen_bc_first
      assign bc_lane_data_in[0]  = bc_buf_data;
      assign bc_lane_valid_in[0] = bc_buf_valid;
      assign bc_buf_ready        = bc_lane_ready_out[0];
    end else begin : gen_bc_next
      assign bc_lane_data_in[l]  = bc_lane_data_out[l-1];
      assign bc_lane_valid_in[l] = bc_lane_valid_out[l-1];
    end

    // nobody downstream of the last lane
    if (l == NrLanes - 1) begin : gen_bc_last
      assign bc_lane_ready_in[l] = 1'b1;
    end else begin : gen_bc_mid
      assign bc_lane_ready_in[l] = bc_lane_ready_out[l+1];
    end
  end : gen_lanes

  vec_lsu i_lsu (
    .clk_i, .rst_n_i,
    .pe        (pe_req.pe   ),
    .ld_valid_i, .ld_ready_o, .ld_data_i,
    .ld_we_o   (ld_we       ),
    .ld_elem_o (ld_elem     ),
    .bc_data_o (bc_buf_data ),
    .bc_valid_o(bc_buf_valid),
    .bc_ready_i(bc_buf_ready),
    .st_elem_i (st_elem     ),
    .st_valid_i(st_valid    ),
    .st_ready_o(st_ready    ),
    .st_valid_o, .st_ready_i, .st_data_o
  );

  // Elaboration checks on the lane count
  if (NrLanes == 0)
    $error("vec_top: at least one lane is needed");

  if (NrLanes != 2**$clog2(NrLanes))
    $error("vec_top: the number of lanes must be a power of two");

  if (NrPEs > 2**$bits(pe_idx_t))
    $error("vec_top: pe_idx_t cannot index every processing element");

endmodule : vec_top

`default_nettype wire

/* sim/tb_vec_top.sv */
// Runs one instruction at a time; the register model assumes no other writer and a fresh reset
`timescale 1ns/1ps
`default_nettype none

module tb_vec_top;
  import vec_pkg::*;

  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 5;
  // Instructions issued over all tests, each bounded by OpCycles
  localparam int unsigned NrOps       = 11;
  localparam int unsigned OpCycles    = 40;
  localparam int unsigned Margin      = 4;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vec_op_e   req_op_i;
  vreg_idx_t req_vd_i;
  vreg_idx_t req_vs1_i;
  vreg_idx_t req_vs2_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  logic      resp_error_o;
  logic      ld_valid_i;
  logic      ld_ready_o;
  beat_t     ld_data_i;
  logic      st_valid_o;
  logic      st_ready_i;
  beat_t     st_data_o;

  // model_q[v][b][l] is element b of register v in lane l
  beat_t model_q [NrVRegs][ElemsPerLane];

  int unsigned checks;
  int unsigned errors;

  vec_top uut (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = !clk_i;

  initial begin
    #(ClkPeriod * (ResetCycles + NrOps * OpCycles) * Margin);
    $display("Watchdog expired, the DUT stopped answering a handshake");
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic beat_t random_beat();
    beat_t b;
    for (int l = 0; l < NrLanes; l++) begin
      b[l] = $urandom();
    end
    return b;
  endfunction

  task automatic compare_beat(input beat_t got, input beat_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0d ns: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic compare_error(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0d ns: resp_error_o expected %b got %b", $time, exp, got);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %0d ns: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus drivers
  //////////////////////////////////////////////////

  task automatic send_request(input vec_op_e op, input vreg_idx_t vd,
                              input vreg_idx_t vs1, input vreg_idx_t vs2);
    logic taken;
    taken       = 1'b0;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_vd_i    = vd;
    req_vs1_i   = vs1;
    req_vs2_i   = vs2;
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      next_cycle();
    end
    req_valid_i = 1'b0;
  endtask

  task automatic drive_beat(input beat_t beat);
    logic taken;
    taken      = 1'b0;
    ld_valid_i = 1'b1;
    ld_data_i  = beat;
    while (!taken) begin
      @(negedge clk_i);
      taken = ld_ready_o;
      next_cycle();
    end
    ld_valid_i = 1'b0;
  endtask

  // Counts the cycles spent before the response shows up
  task automatic wait_response(input logic exp_err, input logic streams_idle,
                               output int unsigned cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen) begin
      @(negedge clk_i);
      compare_flag(req_ready_o, 1'b0, "req_ready_o while busy");
      if (streams_idle) begin
        compare_flag(ld_ready_o, 1'b0, "ld_ready_o");
        compare_flag(st_valid_o, 1'b0, "st_valid_o");
      end
      if (resp_valid_o) begin
        seen = 1'b1;
        compare_error(resp_error_o, exp_err);
      end else begin
        cycles++;
      end
      next_cycle();
    end
  endtask

  //////////////////////////////////////////////////
  // Instructions with model updates
  //////////////////////////////////////////////////

  task automatic do_load(input vreg_idx_t vd);
    beat_t       beat;
    int unsigned cycles;
    send_request(OP_VLOAD, vd, '0, '0);
    for (int b = 0; b < ElemsPerLane; b++) begin
      beat = random_beat();
      model_q[vd][b] = beat;
      drive_beat(beat);
    end
    wait_response(1'b0, 1'b0, cycles);
  endtask

  task automatic do_bcast(input vreg_idx_t vd);
    beat_t       beat;
    int unsigned cycles;
    beat = random_beat();
    send_request(OP_VLOADBC, vd, '0, '0);
    drive_beat(beat);
    for (int b = 0; b < ElemsPerLane; b++) begin
      model_q[vd][b] = {NrLanes{beat[0]}};
    end
    // Exactly one beat, so the load port must close again
    wait_response(1'b0, 1'b1, cycles);
  endtask

  task automatic do_add(input vreg_idx_t vd, input vreg_idx_t vs1, input vreg_idx_t vs2);
    int unsigned cycles;
    send_request(OP_VADD, vd, vs1, vs2);
    wait_response(1'b0, 1'b1, cycles);
    for (int b = 0; b < ElemsPerLane; b++) begin
      for (int l = 0; l < NrLanes; l++) begin
        model_q[vd][b][l] = model_q[vs1][b][l] + model_q[vs2][b][l];
      end
    end
  endtask

  task automatic do_store(input vreg_idx_t vs1, input logic stall);
    int unsigned k;
    int unsigned cycles;
    k = 0;
    send_request(OP_VSTORE, '0, vs1, '0);
    while (k < ElemsPerLane) begin
      st_ready_i = stall ? (($urandom() % 2) == 0) : 1'b1;
      @(negedge clk_i);
      compare_flag(resp_valid_o, 1'b0, "resp_valid_o before the last store beat");
      if (st_valid_o && st_ready_i) begin
        compare_beat(st_data_o, model_q[vs1][k], $sformatf("store beat %0d of v%0d", k, vs1));
        k++;
      end
      next_cycle();
    end
    st_ready_i = 1'b1;
    wait_response(1'b0, 1'b0, cycles);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic end_test(input string name, input int unsigned mark);
    $display("%-20s %0d errors", name, errors - mark);
  endtask

  task automatic test_reset();
    int unsigned mark;
    mark = errors;
    @(negedge clk_i);
    compare_flag(req_ready_o, 1'b1, "req_ready_o after reset");
    compare_flag(resp_valid_o, 1'b0, "resp_valid_o after reset");
    compare_flag(ld_ready_o, 1'b0, "ld_ready_o after reset");
    compare_flag(st_valid_o, 1'b0, "st_valid_o after reset");
    next_cycle();
    end_test("reset state", mark);
  endtask

  task automatic test_round_trip();
    int unsigned mark;
    mark = errors;
    do_load(3'd1);
    do_store(3'd1, 1'b0);
    end_test("load/store", mark);
  endtask

  task automatic test_add();
    int unsigned mark;
    mark = errors;
    do_load(3'd1);
    do_load(3'd2);
    do_add(3'd3, 3'd1, 3'd2);
    do_store(3'd3, 1'b0);
    end_test("vector add", mark);
  endtask

  task automatic test_broadcast();
    int unsigned mark;
    mark = errors;
    do_bcast(3'd4);
    do_store(3'd4, 1'b0);
    end_test("broadcast load", mark);
  endtask

  task automatic test_backpressure();
    int unsigned mark;
    mark = errors;
    do_store(3'd3, 1'b1);
    end_test("store back-pressure", mark);
  endtask

  task automatic test_illegal();
    int unsigned mark;
    int unsigned cycles;
    mark = errors;
    send_request(vec_op_e'(3'd5), 3'd1, 3'd1, 3'd1);
    wait_response(1'b1, 1'b1, cycles);
    if (cycles != 0) begin
      errors++;
      $display("Illegal opcode response came %0d cycles too late", cycles);
    end
    // v1 must be untouched by the rejected request
    do_store(3'd1, 1'b0);
    end_test("illegal opcode", mark);
  endtask

  initial begin
    void'($urandom(1623));
    checks       = 0;
    errors       = 0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = OP_VADD;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    resp_ready_i = 1'b1;
    ld_valid_i   = 1'b0;
    ld_data_i    = '0;
    st_ready_i   = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    test_reset();
    test_round_trip();
    test_add();
    test_broadcast();
    test_backpressure();
    test_illegal();

    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire

/* src.f */
logic/vec_pkg.sv
logic/pe_req_if.sv
logic/stream_fifo.sv
logic/vec_dispatcher.sv
logic/vec_sequencer.sv
logic/vec_lane.sv
logic/vec_lsu.sv
logic/vec_top.sv
sim/tb_vec_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_vec_top -f src.f -Mdir obj_dir &&
./obj_dir/Vtb_vec_top | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
